/* design/fifo_pkg.sv */
// ****************************************
// buffer side types
// ****************************************
package fifo_pkg;

    // one stored data word
    typedef logic [31:0] word_t;

    // occupancy, wide enough for depths up to 2^15
    typedef logic [15:0] count_t;

    // buffer state as seen by both apb ports
    typedef struct packed {
        count_t count;  // words held, output stage included
        logic   full;   // no room for another push
        logic   empty;  // no valid head word
    } fifo_status_t;

endpackage : fifo_pkg

/* design/apb_pkg.sv */
// ****************************************
// apb bus side types and register map
// ****************************************
package apb_pkg;

    // byte address on both ports
    typedef logic [11:0] paddr_t;

    // master to slave
    typedef struct packed {
        logic            psel;
        logic            penable;
        logic            pwrite;
        paddr_t          paddr;
        fifo_pkg::word_t pwdata;
    } apb_req_t;

    // slave to master, no wait states so pready stays high
    typedef struct packed {
        logic            pready;
        fifo_pkg::word_t prdata;
        logic            pslverr;
    } apb_rsp_t;

    // register offsets
    localparam paddr_t DATA_OFS   = 12'h000;  // push / pop data
    localparam paddr_t STATUS_OFS = 12'h004;  // count, full, empty
    localparam paddr_t CTRL_OFS   = 12'h008;  // bit 0 flushes

    // status word layout, count sits in 15:0
    localparam int STATUS_FULL_BIT  = 16;
    localparam int STATUS_EMPTY_BIT = 17;

    // packs buffer state into the STATUS read word
    function automatic fifo_pkg::word_t status_word(input fifo_pkg::fifo_status_t s);
        fifo_pkg::word_t w;
        w                   = '0;
        w[15:0]             = s.count;
        w[STATUS_FULL_BIT]  = s.full;
        w[STATUS_EMPTY_BIT] = s.empty;
        return w;
    endfunction

endpackage : apb_pkg

/* design/fifo_mem.sv */
`timescale 1ns/1ns

module fifo_mem #(
    parameter int ADDR_WIDTH = 4  // log2 of depth
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clear,      // sync flush
    input  logic             push,
    input  fifo_pkg::word_t  push_data,
    input  logic             pop,
    output fifo_pkg::word_t  mem_data,   // valid one cycle after pop
    output logic             mem_empty,
    output logic             mem_full,
    output fifo_pkg::count_t mem_count
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    // pointer with one extra wrap bit
    typedef logic [ADDR_WIDTH:0] ptr_t;

    fifo_pkg::word_t ram [DEPTH];  // storage

    ptr_t wr_ptr;    // next write slot
    ptr_t wr_ptr_q;  // write pointer one cycle late for the read side
    ptr_t rd_ptr;    // next read slot
    ptr_t used;      // words committed to the read side

    logic do_push;
    logic do_pop;

    // clear wins over both strobes
    assign do_push = push && !clear;
    assign do_pop  = pop && !clear;

    // ****************************************
    // pointers
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            wr_ptr_q <= '0;
            rd_ptr   <= '0;
        end else if (clear) begin
            wr_ptr   <= '0;
            wr_ptr_q <= '0;
            rd_ptr   <= '0;
        end else begin
            wr_ptr_q <= wr_ptr;  // new word visible to reader next cycle
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ****************************************
    // ram write and registered read
    // ****************************************
    always_ff @(posedge clk) begin
        if (do_push) begin
            ram[wr_ptr[ADDR_WIDTH-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (do_pop) begin
            mem_data <= ram[rd_ptr[ADDR_WIDTH-1:0]];  // lands one cycle later
        end
    end

    // flags
    assign used      = wr_ptr_q - rd_ptr;
    assign mem_empty = (wr_ptr_q == rd_ptr);  // lags a push by one cycle
    assign mem_full  = (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]) &&
                       (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]);  // live write side
    assign mem_count = fifo_pkg::count_t'(used);

    // the ports must refuse before the core overflows or underflows
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        do_push |-> !mem_full)
        else $error("fifo_mem: push while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        do_pop |-> !mem_empty)
        else $error("fifo_mem: pop while empty");

endmodule : fifo_mem

/* design/fifo_fwft.sv */
`timescale 1ns/1ns

module fifo_fwft #(
    parameter int ADDR_WIDTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  logic                   push,
    input  fifo_pkg::word_t        push_data,
    input  logic                   pop,
    output fifo_pkg::word_t        head,    // valid while status.empty is low
    output fifo_pkg::fifo_status_t status
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic             mem_pop;
    fifo_pkg::word_t  mem_data;
    logic             mem_empty;
    logic             mem_full;
    fifo_pkg::count_t mem_count;
    fifo_pkg::count_t total;
    logic             out_valid;  // head holds a word

    // ****************************************
    // prefetch control
    // ****************************************
    // refill the output stage when it is free or being drained
    assign mem_pop = !mem_empty && (!out_valid || pop) && !flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (mem_pop) begin
            out_valid <= 1'b1;  // refilled even when popped this edge
        end else if (pop) begin
            out_valid <= 1'b0;  // drained with nothing behind it
        end
    end

    // ****************************************
    // status
    // ****************************************
    assign total        = mem_count + fifo_pkg::count_t'(out_valid);  // core plus stage
    assign head         = mem_data;
    assign status.count = total;
    assign status.full  = mem_full || (total == fifo_pkg::count_t'(DEPTH));
    assign status.empty = !out_valid;

    fifo_mem #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_fifo_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (flush),
        .push      (push),
        .push_data (push_data),
        .pop       (mem_pop),
        .mem_data  (mem_data),
        .mem_empty (mem_empty),
        .mem_full  (mem_full),
        .mem_count (mem_count)
    );

    // consumer may only take a word that is there
    a_pop_valid: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> out_valid)
        else $error("fifo_fwft: pop without valid head");

endmodule : fifo_fwft

/* design/apb_push_port.sv */
`timescale 1ns/1ns

module apb_push_port (
    input  logic                   clk,
    input  logic                   rst_n,
    input  apb_pkg::apb_req_t      req,
    output apb_pkg::apb_rsp_t      rsp,
    input  fifo_pkg::fifo_status_t status,
    output logic                   push,
    output fifo_pkg::word_t        push_data,
    output logic                   flush
);

    logic access;     // second cycle of a transfer
    logic wr_data;    // write to DATA
    logic wr_ctrl;    // write to CTRL, any value
    logic rd_status;  // read of STATUS
    logic refused;    // DATA write while full

    // ****************************************
    // address decode
    // ****************************************
    assign access    = req.psel && req.penable;
    assign wr_data   = access && req.pwrite && (req.paddr == apb_pkg::DATA_OFS);
    assign wr_ctrl   = access && req.pwrite && (req.paddr == apb_pkg::CTRL_OFS);
    assign rd_status = access && !req.pwrite && (req.paddr == apb_pkg::STATUS_OFS);

    // strobes, taken by the buffer on the edge ending the access
    assign refused   = wr_data && status.full;
    assign push      = wr_data && !status.full;  // full drops the word
    assign push_data = req.pwdata;
    assign flush     = wr_ctrl && req.pwdata[0];  // ctrl bit 0

    // ****************************************
    // response, combinational
    // ****************************************
    always_comb begin
        rsp.pready  = 1'b1;  // never stalls
        rsp.prdata  = '0;
        rsp.pslverr = 1'b0;
        if (rd_status) begin
            rsp.prdata = apb_pkg::status_word(status);
        end
        if (refused) begin
            rsp.pslverr = 1'b1;
        end else if (access && !(wr_data || wr_ctrl || rd_status)) begin
            rsp.pslverr = 1'b1;  // undefined access
        end
    end

    // master must keep psel up through the access cycle
    a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
        req.penable |-> req.psel)
        else $error("apb_push_port: penable without psel");

endmodule : apb_push_port

/* design/apb_pop_port.sv */
`timescale 1ns/1ns

module apb_pop_port (
    input  logic                   clk,
    input  logic                   rst_n,
    input  apb_pkg::apb_req_t      req,
    output apb_pkg::apb_rsp_t      rsp,
    input  fifo_pkg::fifo_status_t status,
    input  fifo_pkg::word_t        head,
    output logic                   pop
);

    logic access;     // second cycle of a transfer
    logic rd_data;    // read of DATA
    logic rd_status;  // read of STATUS

    // ****************************************
    // address decode
    // ****************************************
    assign access    = req.psel && req.penable;
    assign rd_data   = access && !req.pwrite && (req.paddr == apb_pkg::DATA_OFS);
    assign rd_status = access && !req.pwrite && (req.paddr == apb_pkg::STATUS_OFS);

    // head is already on the lines, drop it at the end of the access
    assign pop = rd_data && !status.empty;

    // response, no registers on this path
    always_comb begin
        rsp.pready  = 1'b1;
        rsp.prdata  = '0;
        rsp.pslverr = 1'b0;
        if (pop) begin
            rsp.prdata = head;
        end else if (rd_status) begin
            rsp.prdata = apb_pkg::status_word(status);
        end else if (access) begin
            // underflow, writes, unknown offsets
            rsp.pslverr = 1'b1;
        end
    end

    a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
        req.penable |-> req.psel)
        else $error("apb_pop_port: penable without psel");

endmodule : apb_pop_port

/* design/apb_fifo_top.sv */
`timescale 1ns/1ns

module apb_fifo_top #(
    parameter int ADDR_WIDTH = 4  // 16 entries by default
) (
    input  logic              clk,
    input  logic              rst_n,
    input  apb_pkg::apb_req_t push_req,
    output apb_pkg::apb_rsp_t push_rsp,
    input  apb_pkg::apb_req_t pop_req,
    output apb_pkg::apb_rsp_t pop_rsp
);

    // ****************************************
    // producer -> buffer -> consumer
    // ****************************************
    logic                   push;
    fifo_pkg::word_t        push_data;
    logic                   flush;
    logic                   pop;
    fifo_pkg::word_t        head;
    fifo_pkg::fifo_status_t status;  // shared by both ports

    apb_push_port u_push_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (push_req),
        .rsp       (push_rsp),
        .status    (status),
        .push      (push),
        .push_data (push_data),
        .flush     (flush)
    );

    fifo_fwft #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_fifo_fwft (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head      (head),
        .status    (status)
    );

    apb_pop_port u_pop_port (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (pop_req),
        .rsp    (pop_rsp),
        .status (status),
        .head   (head),
        .pop    (pop)
    );

endmodule : apb_fifo_top

/* verif/tb_apb_fifo_checks.svh */
`ifndef TB_APB_FIFO_CHECKS_SVH
`define TB_APB_FIFO_CHECKS_SVH

// ****************************************
// check counters and compare tasks
// ****************************************
int pass_count = 0;  // checks that matched
int fail_count = 0;  // checks that did not

// data word or a response that should read as zero
task automatic check_word(input string name, input fifo_pkg::word_t exp,
                          input fifo_pkg::word_t got);
    if (got === exp) begin
        pass_count++;
    end else begin
        fail_count++;
        $display("** Error at %0t ns: %s expected 0x%08h, got 0x%08h",
                 $time, name, exp, got);
    end
endtask

// status word after unpacking into its fields
task automatic check_status(input string name, input fifo_pkg::fifo_status_t exp,
                            input fifo_pkg::fifo_status_t got);
    if (got === exp) begin
        pass_count++;
    end else begin
        fail_count++;
        $display("** Error at %0t ns: %s expected cnt %0d full %0b empty %0b, got %0d %0b %0b",
                 $time, name, exp.count, exp.full, exp.empty,
                 got.count, got.full, got.empty);
    end
endtask

// single flag such as pslverr or pready
task automatic check_err(input string name, input bit exp, input logic got);
    if (got === exp) begin
        pass_count++;
    end else begin
        fail_count++;
        $display("** Error at %0t ns: %s expected %0b, got %0b", $time, name, exp, got);
    end
endtask

`endif

/* verif/tb_apb_fifo.sv */
`timescale 1ns/1ns

module tb_apb_fifo;

    localparam int ADDR_WIDTH = 4;
    localparam int DEPTH      = 1 << ADDR_WIDTH;
    localparam int N_SEQ      = 40;   // words in the ordering test
    localparam int N_FLUSH_WR = 6;    // words written before the flush
    localparam int N_MIXED    = 300;  // random transfers, last test
    // every transfer issued by the six tests
    localparam int N_XFERS = 3 + 2 * N_SEQ + (2 * DEPTH + 3) + 4 + (N_FLUSH_WR + 4) + N_MIXED;
    localparam int TIMEOUT_CYCLES = 40 * N_XFERS + 200;

    logic              clk;
    logic              rst_n;
    apb_pkg::apb_req_t push_req;
    apb_pkg::apb_rsp_t push_rsp;
    apb_pkg::apb_req_t pop_req;
    apb_pkg::apb_rsp_t pop_rsp;

    fifo_pkg::word_t model_q[$];      // expected contents, head first
    int              seed   = 32'hdd62;
    int              cycles = 0;
    int              test_fails = 0;  // fail_count when the test began
    int              sel;
    int              n;

    `include "tb_apb_fifo_checks.svh"

    apb_fifo_top #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .push_req (push_req),
        .push_rsp (push_rsp),
        .pop_req  (pop_req),
        .pop_rsp  (pop_rsp)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;  // 40 ns period

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ****************************************
    // apb driver
    // ****************************************
    task automatic drive_req(input bit on_pop, input apb_pkg::apb_req_t req);
        if (on_pop) begin
            pop_req <= req;
        end else begin
            push_req <= req;
        end
    endtask

    // setup, access, then one idle cycle so the fall-through stage settles
    task automatic apb_transfer(input bit on_pop, input logic wr, input apb_pkg::paddr_t addr,
                                input fifo_pkg::word_t wdata, output apb_pkg::apb_rsp_t rsp);
        apb_pkg::apb_req_t req;
        req        = '0;
        req.psel   = 1'b1;
        req.pwrite = wr;
        req.paddr  = addr;
        req.pwdata = wdata;
        @(posedge clk);
        drive_req(on_pop, req);
        @(posedge clk);
        req.penable = 1'b1;
        drive_req(on_pop, req);
        @(negedge clk);  // mid access cycle
        rsp = on_pop ? pop_rsp : push_rsp;
        check_err(on_pop ? "pop_rsp.pready" : "push_rsp.pready", 1'b1, rsp.pready);
        @(posedge clk);
        drive_req(on_pop, '0);
    endtask

    // ****************************************
    // reference model
    // ****************************************
    function automatic fifo_pkg::fifo_status_t model_status();
        fifo_pkg::fifo_status_t s;
        s.count = fifo_pkg::count_t'(model_q.size());
        s.full  = (model_q.size() == DEPTH);
        s.empty = (model_q.size() == 0);
        return s;
    endfunction

    // count 15:0, full 16, empty 17
    function automatic fifo_pkg::fifo_status_t unpack_status(input fifo_pkg::word_t w);
        fifo_pkg::fifo_status_t s;
        s.count = w[15:0];
        s.full  = w[16];
        s.empty = w[17];
        return s;
    endfunction

    task automatic push_access(input logic wr, input apb_pkg::paddr_t addr,
                               input fifo_pkg::word_t wdata);
        apb_pkg::apb_rsp_t      rsp;
        fifo_pkg::fifo_status_t exp_st;
        bit                     exp_err;
        exp_st  = model_status();  // state seen during the access
        exp_err = 1'b1;            // undefined unless decoded below
        apb_transfer(1'b0, wr, addr, wdata, rsp);
        if (wr && addr == apb_pkg::DATA_OFS) begin
            exp_err = exp_st.full;  // full drops the word
            if (!exp_st.full) begin
                model_q.push_back(wdata);
            end
        end else if (wr && addr == apb_pkg::CTRL_OFS) begin
            exp_err = 1'b0;
            if (wdata[0]) begin
                model_q.delete();
            end
        end else if (!wr && addr == apb_pkg::STATUS_OFS) begin
            exp_err = 1'b0;
            check_status("push_rsp.prdata", exp_st, unpack_status(rsp.prdata));
            check_word("push_rsp.prdata[31:18]", '0, rsp.prdata & 32'hfffc_0000);
        end
        if (wr || exp_err) begin
            check_word("push_rsp.prdata", '0, rsp.prdata);
        end
        check_err("push_rsp.pslverr", exp_err, rsp.pslverr);
    endtask

    task automatic pop_access(input logic wr, input apb_pkg::paddr_t addr);
        apb_pkg::apb_rsp_t      rsp;
        fifo_pkg::fifo_status_t exp_st;
        fifo_pkg::word_t        exp_word;
        exp_st = model_status();
        apb_transfer(1'b1, wr, addr, $random(seed), rsp);
        if (!wr && addr == apb_pkg::DATA_OFS && !exp_st.empty) begin
            exp_word = model_q.pop_front();
            check_word("pop_rsp.prdata", exp_word, rsp.prdata);
            check_err("pop_rsp.pslverr", 1'b0, rsp.pslverr);
        end else if (!wr && addr == apb_pkg::STATUS_OFS) begin
            check_status("pop_rsp.prdata", exp_st, unpack_status(rsp.prdata));
            check_word("pop_rsp.prdata[31:18]", '0, rsp.prdata & 32'hfffc_0000);
            check_err("pop_rsp.pslverr", 1'b0, rsp.pslverr);
        end else begin
            check_word("pop_rsp.prdata", '0, rsp.prdata);  // underflow or bad access
            check_err("pop_rsp.pslverr", 1'b1, rsp.pslverr);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s %s, %0d errors", name,
                 (fail_count == test_fails) ? "ok" : "with errors", fail_count - test_fails);
        test_fails = fail_count;
    endtask

    // ****************************************
    // tests
    // ****************************************
    initial begin
        rst_n    = 1'b0;
        push_req = '0;
        pop_req  = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        push_access(1'b0, apb_pkg::STATUS_OFS, '0);
        pop_access(1'b0, apb_pkg::STATUS_OFS);
        pop_access(1'b0, apb_pkg::DATA_OFS);
        end_test("reset");

        // batches that fit the depth so no write is refused
        for (int done = 0; done < N_SEQ; done += n) begin
            n = (N_SEQ - done < DEPTH) ? N_SEQ - done : DEPTH;
            repeat (n) push_access(1'b1, apb_pkg::DATA_OFS, $random(seed));
            repeat (n) pop_access(1'b0, apb_pkg::DATA_OFS);
        end
        end_test("order");

        repeat (DEPTH) push_access(1'b1, apb_pkg::DATA_OFS, $random(seed));
        push_access(1'b0, apb_pkg::STATUS_OFS, '0);           // full, count 16
        push_access(1'b1, apb_pkg::DATA_OFS, $random(seed));  // refused
        repeat (DEPTH) pop_access(1'b0, apb_pkg::DATA_OFS);
        pop_access(1'b0, apb_pkg::STATUS_OFS);
        end_test("full");

        pop_access(1'b0, apb_pkg::DATA_OFS);  // underflow
        pop_access(1'b1, apb_pkg::DATA_OFS);
        push_access(1'b0, apb_pkg::CTRL_OFS, '0);
        pop_access(1'b0, apb_pkg::STATUS_OFS);
        end_test("empty and bad");

        repeat (N_FLUSH_WR) push_access(1'b1, apb_pkg::DATA_OFS, $random(seed));
        push_access(1'b1, apb_pkg::CTRL_OFS, 32'h1);
        push_access(1'b0, apb_pkg::STATUS_OFS, '0);
        push_access(1'b1, apb_pkg::DATA_OFS, $random(seed));
        pop_access(1'b0, apb_pkg::DATA_OFS);  // first word after the flush
        end_test("flush");

        // pushes slightly outweigh pops so the buffer drifts toward full
        repeat (N_MIXED) begin
            sel = {$random(seed)} % 16;
            if (sel < 7) begin
                push_access(1'b1, apb_pkg::DATA_OFS, $random(seed));
            end else if (sel < 12) begin
                pop_access(1'b0, apb_pkg::DATA_OFS);
            end else if (sel == 12) begin
                push_access(1'b0, apb_pkg::STATUS_OFS, '0);
            end else if (sel == 13) begin
                pop_access(1'b0, apb_pkg::STATUS_OFS);
            end else if (sel == 14) begin
                push_access(1'b1, apb_pkg::CTRL_OFS, $random(seed));  // flush on bit 0
            end else begin
                push_access(1'b0, apb_pkg::DATA_OFS, '0);  // read of push data
            end
        end
        end_test("mixed");

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : tb_apb_fifo

/* flist.f */
+incdir+verif
design/fifo_pkg.sv
design/apb_pkg.sv
design/fifo_mem.sv
design/fifo_fwft.sv
design/apb_push_port.sv
design/apb_pop_port.sv
design/apb_fifo_top.sv
verif/tb_apb_fifo.sv

/* Makefile */
# Verilator build and run for the APB mailbox FIFO

VERILATOR ?= verilator
TOP       ?= tb_apb_fifo
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard design/*.sv verif/*.sv verif/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# pass only when the log holds the pass line
run: compile
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TESTBENCH PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
